// ==== design/busCpuPkg.sv ====
package busCpuPkg;

    localparam int dataWidth = 32;
    localparam int constWidth = 18;

    // 5-bit ALU opcodes
    localparam logic [4:0] opAdd  = 5'd3;
    localparam logic [4:0] opSub  = 5'd4;
    localparam logic [4:0] opAnd  = 5'd5;
    localparam logic [4:0] opOr   = 5'd6;
    localparam logic [4:0] opShr  = 5'd7;
    localparam logic [4:0] opShra = 5'd8;
    localparam logic [4:0] opShl  = 5'd9;
    localparam logic [4:0] opRor  = 5'd10;
    localparam logic [4:0] opRol  = 5'd11;
    localparam logic [4:0] opMul  = 5'd15;
    localparam logic [4:0] opDiv  = 5'd16;
    localparam logic [4:0] opNeg  = 5'd17;
    localparam logic [4:0] opNot  = 5'd18;

    // bus source select
    localparam logic [3:0] srcNone   = 4'd0;
    localparam logic [3:0] srcPc     = 4'd1;
    localparam logic [3:0] srcMdr    = 4'd2;
    localparam logic [3:0] srcZLow   = 4'd3;
    localparam logic [3:0] srcZHigh  = 4'd4;
    localparam logic [3:0] srcHi     = 4'd5;
    localparam logic [3:0] srcLo     = 4'd6;
    localparam logic [3:0] srcInPort = 4'd7;
    localparam logic [3:0] srcConst  = 4'd8;
    localparam logic [3:0] srcReg    = 4'd9;

    // which instruction field names the register
    localparam logic [1:0] fieldRa = 2'd0;
    localparam logic [1:0] fieldRb = 2'd1;
    localparam logic [1:0] fieldRc = 2'd2;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [14:0] unused;
    } rFormatT;

    typedef struct packed {
        logic [4:0]            opcode;
        logic [3:0]            ra;
        logic [3:0]            rb;
        logic                  spare; // bit 18, not part of the constant
        logic [constWidth-1:0] c;
    } iFormatT;

    typedef union packed {
        rFormatT rFormat;
        iFormatT iFormat;
    } instrWord;

endpackage

// ==== design/aluIf.sv ====
`timescale 1ns/100ps
interface aluIf import busCpuPkg::*; ();

    logic [dataWidth-1:0]   operandA; // from Y
    logic [dataWidth-1:0]   operandB; // the bus
    logic [4:0]             opcode;
    logic                   incPc;
    logic [2*dataWidth-1:0] result;

    modport dpSide (output operandA, output operandB, output opcode, output incPc,
                    input result);
    modport aluSide (input operandA, input operandB, input opcode, input incPc,
                     output result);

endinterface

// ==== design/aluUnit.sv ====
`timescale 1ns/100ps
module aluUnit import busCpuPkg::*; (
    aluIf.aluSide alu
);

    logic signed [dataWidth-1:0]   sA;
    logic signed [dataWidth-1:0]   sB;
    logic signed [2*dataWidth-1:0] product;
    logic [4:0]                    amount;
    logic [dataWidth-1:0]          quotient;
    logic [dataWidth-1:0]          remainder;

    assign sA = alu.operandA;
    assign sB = alu.operandB;
    assign amount = alu.operandB[4:0];
    assign product = sA * sB; // operands widen to 64 bits, signed

    always_comb begin
        if (sB == '0) begin
            quotient = '1; // divide by zero
            remainder = alu.operandA;
        end else if (sB == -1) begin
            quotient = '0 - alu.operandA; // avoids the min / -1 overflow
            remainder = '0;
        end else begin
            quotient = sA / sB;
            remainder = sA % sB;
        end
    end

    always_comb begin
        alu.result = '0;
        if (alu.incPc) begin
            alu.result[dataWidth-1:0] = alu.operandB + 1'b1; // fetch step
        end else begin
            case (alu.opcode)
                opAdd: begin
                    alu.result[dataWidth-1:0] = alu.operandA + alu.operandB;
                end
                opSub: begin
                    alu.result[dataWidth-1:0] = alu.operandA - alu.operandB;
                end
                opAnd: begin
                    alu.result[dataWidth-1:0] = alu.operandA & alu.operandB;
                end
                opOr: begin
                    alu.result[dataWidth-1:0] = alu.operandA | alu.operandB;
                end
                opShr: begin
                    alu.result[dataWidth-1:0] = alu.operandA >> amount;
                end
                opShra: begin
                    alu.result[dataWidth-1:0] = sA >>> amount;
                end
                opShl: begin
                    alu.result[dataWidth-1:0] = alu.operandA << amount;
                end
                opRor: begin
                    alu.result[dataWidth-1:0] = alu.operandA >> amount
                        | alu.operandA << (6'd32 - {1'b0, amount});
                end
                opRol: begin
                    alu.result[dataWidth-1:0] = alu.operandA << amount
                        | alu.operandA >> (6'd32 - {1'b0, amount});
                end
                opMul: begin
                    alu.result = product;
                end
                opDiv: begin
                    alu.result = {remainder, quotient};
                end
                opNeg: begin
                    alu.result[dataWidth-1:0] = '0 - alu.operandB; // unary ops take the bus
                end
                opNot: begin
                    alu.result[dataWidth-1:0] = ~alu.operandB;
                end
                default: begin
                    alu.result = '0;
                end
            endcase
        end
    end

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/100ps
module regFile import busCpuPkg::*; (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 writeEnable,
    input  logic [3:0]           regIndex,
    input  logic [dataWidth-1:0] writeData,
    output logic [dataWidth-1:0] readData
);

    logic [dataWidth-1:0] regs [16];

    // one index for both ports since a register is either source or sink per cycle
    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[regIndex] <= writeData;
        end
    end

    assign readData = regs[regIndex]; // combinational read

endmodule

// ==== design/selectEncode.sv ====
`timescale 1ns/100ps
module selectEncode import busCpuPkg::*; (
    input  instrWord             irValue,
    input  logic [1:0]           regField,
    output logic [3:0]           regIndex,
    output logic [dataWidth-1:0] constValue
);

    logic signBit;

    always_comb begin
        case (regField)
            fieldRa: begin
                regIndex = irValue.rFormat.ra;
            end
            fieldRb: begin
                regIndex = irValue.rFormat.rb;
            end
            fieldRc: begin
                regIndex = irValue.rFormat.rc;
            end
            default: begin
                regIndex = '0;
            end
        endcase
    end

    // same bits as rc above, read as the immediate here
    assign signBit = irValue.iFormat.c[constWidth-1];
    assign constValue = {{(dataWidth-constWidth){signBit}}, irValue.iFormat.c};

endmodule

// ==== design/busDatapath.sv ====
`timescale 1ns/100ps
module busDatapath import busCpuPkg::*; (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic [3:0]           busSource,
    input  logic [1:0]           regField,
    input  logic                 regWrite,
    input  logic                 marEn,
    input  logic                 mdrEn,
    input  logic                 read,
    input  logic                 irEn,
    input  logic                 yEn,
    input  logic                 zEn,
    input  logic                 pcEn,
    input  logic                 hiEn,
    input  logic                 loEn,
    input  logic                 incPc,
    input  logic [4:0]           opcode,
    input  logic [dataWidth-1:0] memDataIn,
    input  logic [dataWidth-1:0] inPort,
    output logic [dataWidth-1:0] busValue,
    output logic [dataWidth-1:0] pcValue,
    output logic [dataWidth-1:0] marValue,
    output logic [dataWidth-1:0] hiValue,
    output logic [dataWidth-1:0] loValue
);

    logic [dataWidth-1:0]   pc;
    logic [dataWidth-1:0]   mar;
    logic [dataWidth-1:0]   mdr;
    logic [dataWidth-1:0]   y;
    logic [dataWidth-1:0]   hi;
    logic [dataWidth-1:0]   lo;
    logic [2*dataWidth-1:0] z;
    instrWord               ir;
    logic [3:0]             regIndex;
    logic [dataWidth-1:0]   regData;
    logic [dataWidth-1:0]   constValue;

    aluIf alu ();

    assign alu.operandA = y;
    assign alu.operandB = busValue;
    assign alu.opcode = opcode;
    assign alu.incPc = incPc;

    aluUnit i_aluUnit (
        .alu (alu.aluSide)
    );

    selectEncode i_selectEncode (
        .irValue    (ir),
        .regField   (regField),
        .regIndex   (regIndex),
        .constValue (constValue)
    );

    regFile i_regFile (
        .Clock       (Clock),
        .rst         (rst),
        .writeEnable (regWrite),
        .regIndex    (regIndex),
        .writeData   (busValue),
        .readData    (regData)
    );

    // single driver on the bus each cycle
    always_comb begin
        case (busSource)
            srcPc:     busValue = pc;
            srcMdr:    busValue = mdr;
            srcZLow:   busValue = z[dataWidth-1:0];
            srcZHigh:  busValue = z[2*dataWidth-1:dataWidth];
            srcHi:     busValue = hi;
            srcLo:     busValue = lo;
            srcInPort: busValue = inPort;
            srcConst:  busValue = constValue;
            srcReg:    busValue = regData;
            default:   busValue = '0; // srcNone and unused codes
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            pc <= '0;
            mar <= '0;
            mdr <= '0;
            ir <= '0;
            y <= '0;
            z <= '0;
            hi <= '0;
            lo <= '0;
        end else begin
            if (pcEn) pc <= busValue;
            if (marEn) mar <= busValue;
            if (mdrEn) mdr <= read ? memDataIn : busValue; // memory read or bus
            if (irEn) ir <= busValue;
            if (yEn) y <= busValue;
            if (zEn) z <= alu.result;
            if (hiEn) hi <= busValue;
            if (loEn) lo <= busValue;
        end
    end

    assign pcValue = pc;
    assign marValue = mar;
    assign hiValue = hi;
    assign loValue = lo;

endmodule

// ==== dv/busDatapath_sva.sv ====
`timescale 1ns/100ps
module busDatapathSva import busCpuPkg::*; (
    input logic                 Clock,
    input logic                 rst,
    input logic                 marEn,
    input logic                 hiEn,
    input logic                 loEn,
    input logic [dataWidth-1:0] busValue,
    input logic [dataWidth-1:0] pcValue,
    input logic [dataWidth-1:0] marValue,
    input logic [dataWidth-1:0] hiValue,
    input logic [dataWidth-1:0] loValue
);

    marLoad: assert property (@(posedge Clock) disable iff (rst)
        marEn |=> marValue == $past(busValue))
        else $error("MAR did not take the bus value");

    // only the register whose enable was high has to follow the bus
    hiLoLoad: assert property (@(posedge Clock) disable iff (rst)
        (hiEn || loEn) |=> (!$past(hiEn) || hiValue == $past(busValue))
            && (!$past(loEn) || loValue == $past(busValue)))
        else $error("HI or LO did not take the bus value");

    pcReset: assert property (@(posedge Clock) rst |=> pcValue == '0)
        else $error("PC was not cleared by reset");

endmodule

bind busDatapath busDatapathSva i_busDatapathSva (
    .Clock    (Clock),
    .rst      (rst),
    .marEn    (marEn),
    .hiEn     (hiEn),
    .loEn     (loEn),
    .busValue (busValue),
    .pcValue  (pcValue),
    .marValue (marValue),
    .hiValue  (hiValue),
    .loValue  (loValue)
);

// ==== dv/busDatapathTb.sv ====
`timescale 1ns/100ps
module busDatapathTb import busCpuPkg::*; ();

    localparam int clockPeriod = 100;
    localparam int maxTests = 64;
    localparam int resetSteps = 5 + 16 * 3; // control steps per test, sizes the watchdog
    localparam int regSteps = 2 + 3 * 3 + 3;
    localparam int aluSteps = 8;
    localparam int fixedSteps = resetSteps + regSteps + 2 + (1 + 4 * 2) + 2 * 3;

    logic                 Clock;
    logic                 rst;
    logic [3:0]           busSource;
    logic [1:0]           regField;
    logic                 regWrite;
    logic                 marEn;
    logic                 mdrEn;
    logic                 read;
    logic                 irEn;
    logic                 yEn;
    logic                 zEn;
    logic                 pcEn;
    logic                 hiEn;
    logic                 loEn;
    logic                 incPc;
    logic [4:0]           opcode;
    logic [dataWidth-1:0] memDataIn;
    logic [dataWidth-1:0] inPort;
    logic [dataWidth-1:0] busValue;
    logic [dataWidth-1:0] pcValue;
    logic [dataWidth-1:0] marValue;
    logic [dataWidth-1:0] hiValue;
    logic [dataWidth-1:0] loValue;
    logic [dataWidth-1:0] patterns [maxTests*5]; // five words per test
    int                   numTests;
    bit                   loaded;
    int                   errors;
    int                   passedTests;
    int                   failedTests;

    busDatapath i_busDatapath (.*);

    initial begin
        Clock = 1'b0;
        forever #(clockPeriod / 2) Clock = ~Clock;
    end

    initial begin
        wait (loaded);
        #(2 * (fixedSteps + aluSteps * numTests) * clockPeriod);
        $display("the simulation timed out before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    task automatic setControls(input logic [3:0] src, input logic [1:0] field);
        busSource = src;
        regField = field;
        {regWrite, marEn, mdrEn, read, irEn, yEn, zEn, pcEn, hiEn, loEn, incPc} = '0;
        opcode = '0;
    endtask

    task automatic expectValue(input logic [dataWidth-1:0] actual,
                               input logic [dataWidth-1:0] expected, input string what);
        assert (actual === expected)
        else begin
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, actual,
                     expected);
            errors++;
        end
    endtask

    task automatic loadMdr(input logic [dataWidth-1:0] word);
        setControls(srcNone, fieldRa);
        memDataIn = word;
        mdrEn = 1'b1;
        read = 1'b1; // memory side of the MDR
        @(negedge Clock);
    endtask

    task automatic loadIr(input logic [dataWidth-1:0] word);
        loadMdr(word);
        setControls(srcMdr, fieldRa);
        irEn = 1'b1;
        @(negedge Clock);
    endtask

    task automatic writeReg(input logic [1:0] field, input logic [dataWidth-1:0] word);
        loadMdr(word);
        setControls(srcMdr, field);
        regWrite = 1'b1;
        @(negedge Clock);
    endtask

    task automatic readReg(input logic [1:0] field);
        setControls(srcReg, field);
        @(negedge Clock);
    endtask

    function automatic logic [dataWidth-1:0] rWord(input logic [3:0] ra, rb, rc);
        return {5'd0, ra, rb, rc, 15'd0};
    endfunction

    task automatic finishTest(input string name, input int errorsBefore);
        if (errors == errorsBefore) begin
            passedTests++;
            $display("test %s: pass", name);
        end else begin
            failedTests++;
            $display("test %s: fail", name);
        end
    endtask

    initial begin
        int                   startErrors;
        logic [dataWidth-1:0] expectedPc;
        logic [17:0]          c;
        logic [17:0]          constFields [2];
        logic [dataWidth-1:0] constExpected [2];
        logic [1:0]           fields [3];
        logic [dataWidth-1:0] regValues [3];
        rst = 1'b1;
        memDataIn = '0;
        inPort = '0;
        setControls(srcNone, fieldRa);
        foreach (patterns[i]) patterns[i] = '0;
        $readmemh("dv/busDatapathPatterns.dat", patterns);
        while (numTests < maxTests && patterns[numTests*5] != 0) numTests++; // opcode 0 ends
        if (numTests == 0) begin
            $display("no test patterns could be read from dv/busDatapathPatterns.dat");
            errors++;
        end
        loaded = 1'b1;

        startErrors = errors;
        repeat (5) @(negedge Clock);
        rst = 1'b0;
        expectValue(pcValue, '0, "pcValue after reset");
        expectValue(marValue, '0, "marValue after reset");
        expectValue(hiValue, '0, "hiValue after reset");
        expectValue(loValue, '0, "loValue after reset");
        for (int i = 0; i < 16; i++) begin
            loadIr(rWord(i[3:0], 4'd0, 4'd0));
            readReg(fieldRa);
            expectValue(busValue, '0, $sformatf("register %0d after reset", i));
        end
        finishTest("reset", startErrors);

        startErrors = errors;
        fields = '{fieldRa, fieldRb, fieldRc};
        regValues = '{32'hdeadbeef, 32'h0badf00d, 32'h13572468};
        loadIr(rWord(4'd3, 4'd7, 4'd12));
        for (int f = 0; f < 3; f++) begin
            writeReg(fields[f], regValues[f]);
            readReg(fields[f]);
            expectValue(busValue, regValues[f], $sformatf("field %0d read-back", f));
        end
        for (int f = 0; f < 3; f++) begin // later writes must leave earlier ones alone
            readReg(fields[f]);
            expectValue(busValue, regValues[f], $sformatf("field %0d second read", f));
        end
        finishTest("register load", startErrors);

        loadIr(rWord(4'd0, 4'd1, 4'd2));
        for (int t = 0; t < numTests; t++) begin
            startErrors = errors;
            writeReg(fieldRb, patterns[t*5+1]);
            writeReg(fieldRc, patterns[t*5+2]);
            setControls(srcReg, fieldRb);
            yEn = 1'b1;
            @(negedge Clock);
            setControls(srcReg, fieldRc);
            opcode = patterns[t*5][4:0];
            zEn = 1'b1;
            @(negedge Clock);
            setControls(srcZLow, fieldRa);
            loEn = 1'b1;
            @(negedge Clock);
            expectValue(busValue, patterns[t*5+3], "ZLow on the bus");
            expectValue(loValue, patterns[t*5+3], "loValue");
            setControls(srcZHigh, fieldRa);
            hiEn = 1'b1;
            @(negedge Clock);
            expectValue(hiValue, patterns[t*5+4], "hiValue");
            finishTest($sformatf("alu %0d opcode %h", t, patterns[t*5][4:0]), startErrors);
        end

        startErrors = errors;
        expectedPc = 32'h0000fffe; // crosses a 16-bit boundary on the way
        setControls(srcInPort, fieldRa);
        inPort = expectedPc;
        pcEn = 1'b1;
        @(negedge Clock);
        expectValue(pcValue, expectedPc, "pcValue from the input port");
        for (int n = 0; n < 4; n++) begin
            setControls(srcPc, fieldRa);
            marEn = 1'b1;
            zEn = 1'b1;
            incPc = 1'b1;
            @(negedge Clock);
            setControls(srcZLow, fieldRa);
            pcEn = 1'b1;
            @(negedge Clock);
            expectValue(marValue, expectedPc, "marValue after fetch");
            expectedPc = expectedPc + 32'd1;
            expectValue(pcValue, expectedPc, "pcValue after fetch");
        end
        finishTest("fetch increment", startErrors);

        startErrors = errors;
        constFields = '{18'h20005, 18'h12345};
        constExpected = '{32'hfffe0005, 32'h00012345};
        for (int k = 0; k < 2; k++) begin
            c = constFields[k];
            loadIr({5'd0, 4'd5, 4'd6, 1'b0, c});
            setControls(srcConst, fieldRa);
            @(negedge Clock);
            expectValue(busValue, constExpected[k], "constant on the bus");
        end
        finishTest("constant path", startErrors);

        $display("summary: %0d passing tests, %0d failing tests, %0d check errors",
                 passedTests, failedTests, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== busCpu.f ====
design/busCpuPkg.sv
design/aluIf.sv
design/aluUnit.sv
design/regFile.sv
design/selectEncode.sv
design/busDatapath.sv
dv/busDatapath_sva.sv
dv/busDatapathTb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module busDatapathTb -f busCpu.f -o busDatapathSim || exit 1
result=$(./obj_dir/busDatapathSim)
echo "$result"
echo "$result" | grep -qx "TESTS PASSED" && exit 0 || exit 1

// ==== dv/busDatapathPatterns.dat ====
// opcode operandA operandB expectedLo expectedHi, all hex, one ALU test per line
// operandA goes through Y, operandB is the bus word; neg and not use operandB only
03 00000005 00000007 0000000c 00000000
03 ffffffff 00000001 00000000 00000000
04 00000010 00000020 fffffff0 00000000
04 80000000 00000001 7fffffff 00000000
05 f0f0f0f0 ff00ff00 f000f000 00000000
06 0000f0f0 12340000 1234f0f0 00000000
07 80000000 00000004 08000000 00000000
08 80000000 00000004 f8000000 00000000
08 40000000 00000024 04000000 00000000
09 00000003 0000001f 80000000 00000000
0a 12345678 00000008 78123456 00000000
0b 12345678 00000004 23456781 00000000
11 00000000 00000005 fffffffb 00000000
12 00000000 0f0f0f0f f0f0f0f0 00000000
0f 00000006 00000007 0000002a 00000000
0f fffffffd 00000004 fffffff4 ffffffff
0f 00010000 00010000 00000000 00000001
0f 80000000 80000000 00000000 40000000
10 00000064 00000007 0000000e 00000002
10 fffffff9 00000002 fffffffd ffffffff
10 0000002a 00000000 ffffffff 0000002a
01 12345678 11111111 00000000 00000000
